// ==== verilog/clk_pkg.sv ====
package clk_pkg;

  // CPU speed selection
  typedef enum logic [1:0] {
    SPEED_3M5 = 2'd0,  // 28 MHz / 8
    SPEED_7M  = 2'd1,  // 28 MHz / 4
    SPEED_14M = 2'd2   // 28 MHz / 2
  } speed_t;

  // Master divider
  localparam int DIV_W = 3;

  // Divider value where speed changes are applied
  localparam logic [DIV_W-1:0] DIV_WRAP = '1;

  // Terminal count masks, one per speed
  // Enable fires when the masked divider bits are all ones
  localparam logic [DIV_W-1:0] MASK_14M = 3'b001;
  localparam logic [DIV_W-1:0] MASK_7M  = 3'b011;
  localparam logic [DIV_W-1:0] MASK_3M5 = 3'b111;

  // PLL option width
  localparam int PLL_OPT_W = 3;

  // Edges from option update to reconfiguration step
  localparam int RECONF_DELAY = 7;

  // Request FIFO geometry
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_AW    = 2;

endpackage

// ==== verilog/speed_request.sv ====
`timescale 1ns/10ps

module speed_request
  import clk_pkg::*;
(
  input  logic       CLK_OUT1,
  input  logic       rst_n,
  input  logic [1:0] turbo_enable,
  output logic       in_req,
  output speed_t     in_speed,
  input  logic       in_ack
);

  // Sender side of the four-phase link
  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT_ACK_LOW
  } state_t;

  state_t state;
  speed_t decoded;
  speed_t dec_q;
  speed_t last_sent;

  // Bit 1 wins over bit 0
  always_comb begin
    if (turbo_enable[1]) begin
      decoded = SPEED_14M;
    end else if (turbo_enable[0]) begin
      decoded = SPEED_7M;
    end else begin
      decoded = SPEED_3M5;
    end
  end

  always_ff @(posedge CLK_OUT1) begin
    if (!rst_n) begin
      state     <= IDLE;
      in_req    <= 1'b0;
      dec_q     <= SPEED_3M5;
      last_sent <= SPEED_3M5;
    end else begin
      // One edge of decode latency
      dec_q <= decoded;
      case (state)
        IDLE: begin
          // Send only a real change, latest value wins
          if (dec_q != last_sent) begin
            in_req    <= 1'b1;
            last_sent <= dec_q;
            state     <= REQ;
          end
        end
        REQ: begin
          // Held here while the FIFO is full
          if (in_ack) begin
            in_req <= 1'b0;
            state  <= WAIT_ACK_LOW;
          end
        end
        WAIT_ACK_LOW: begin
          if (!in_ack) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Payload follows the request launch
  always_ff @(posedge CLK_OUT1) begin
    if (state == IDLE && dec_q != last_sent) begin
      in_speed <= dec_q;
    end
  end

  // Data must hold for the whole request phase
  a_speed_stable : assert property (@(posedge CLK_OUT1) disable iff (!rst_n)
    in_req && $past(in_req) |-> in_speed == $past(in_speed))
    else $error("speed_request: in_speed changed during request");

endmodule

// ==== verilog/speed_fifo.sv ====
`timescale 1ns/10ps

module speed_fifo
  import clk_pkg::*;
(
  input  logic   CLK_OUT1,
  input  logic   rst_n,
  input  logic   in_req,
  input  speed_t in_speed,
  output logic   in_ack,
  output logic   out_req,
  output speed_t out_speed,
  input  logic   out_ack
);

  typedef enum logic {
    RX_IDLE,
    RX_ACK
  } rx_state_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_REQ,
    TX_WAIT
  } tx_state_t;

  rx_state_t          rx_state;
  tx_state_t          tx_state;
  speed_t             mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;
  logic               full;
  logic               empty;
  logic               wr_en;
  logic               rd_en;

  assign full  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
  assign empty = (count == '0);

  // Ack withheld while full, producer keeps req up
  assign wr_en = (rx_state == RX_IDLE) && in_req && !full;
  // Entry leaves on the consumer ack
  assign rd_en = (tx_state == TX_REQ) && out_ack;

  // Receiver side
  always_ff @(posedge CLK_OUT1) begin
    if (!rst_n) begin
      rx_state <= RX_IDLE;
      in_ack   <= 1'b0;
      wr_ptr   <= '0;
    end else begin
      case (rx_state)
        RX_IDLE: begin
          if (wr_en) begin
            in_ack   <= 1'b1;
            wr_ptr   <= wr_ptr + 1'b1;
            rx_state <= RX_ACK;
          end
        end
        RX_ACK: begin
          // Close once the sender lets go
          if (!in_req) begin
            in_ack   <= 1'b0;
            rx_state <= RX_IDLE;
          end
        end
        default: rx_state <= RX_IDLE;
      endcase
    end
  end

  // Storage
  always_ff @(posedge CLK_OUT1) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_speed;
    end
  end

  // Sender side
  always_ff @(posedge CLK_OUT1) begin
    if (!rst_n) begin
      tx_state <= TX_IDLE;
      out_req  <= 1'b0;
      rd_ptr   <= '0;
    end else begin
      case (tx_state)
        TX_IDLE: begin
          // Oldest entry goes out once the last handshake closed
          if (!empty) begin
            out_req  <= 1'b1;
            tx_state <= TX_REQ;
          end
        end
        TX_REQ: begin
          if (out_ack) begin
            out_req  <= 1'b0;
            rd_ptr   <= rd_ptr + 1'b1;
            tx_state <= TX_WAIT;
          end
        end
        TX_WAIT: begin
          if (!out_ack) begin
            tx_state <= TX_IDLE;
          end
        end
        default: tx_state <= TX_IDLE;
      endcase
    end
  end

  // Output payload latched at launch
  always_ff @(posedge CLK_OUT1) begin
    if (tx_state == TX_IDLE && !empty) begin
      out_speed <= mem[rd_ptr];
    end
  end

  // Occupancy
  always_ff @(posedge CLK_OUT1) begin
    if (!rst_n) begin
      count <= '0;
    end else if (wr_en && !rd_en) begin
      count <= count + 1'b1;
    end else if (rd_en && !wr_en) begin
      count <= count - 1'b1;
    end
  end

  a_no_write_full : assert property (@(posedge CLK_OUT1) disable iff (!rst_n)
    full && !rd_en |=> $stable(wr_ptr))
    else $error("speed_fifo: write while full");

  a_no_read_empty : assert property (@(posedge CLK_OUT1) disable iff (!rst_n)
    empty |=> $stable(rd_ptr))
    else $error("speed_fifo: read while empty");

endmodule

// ==== verilog/cpu_clken_gen.sv ====
`timescale 1ns/10ps

module cpu_clken_gen
  import clk_pkg::*;
(
  input  logic   CLK_OUT1,
  input  logic   rst_n,
  input  logic   cpu_contention,
  input  logic   out_req,
  input  speed_t out_speed,
  output logic   out_ack,
  output logic   cpu_clken,
  output speed_t cpu_speed
);

  logic [DIV_W-1:0] div;
  logic [DIV_W-1:0] tc_mask;
  logic             div_wrap;
  logic             term_cnt;

  // Free-running master divider
  always_ff @(posedge CLK_OUT1) begin
    if (!rst_n) begin
      div <= '0;
    end else begin
      div <= div + 1'b1;
    end
  end

  assign div_wrap = (div == DIV_WRAP);

  // Speed register, consumer side of the link
  // Changes land only on the wrap, where every mask is satisfied,
  // so the old rate finishes its period cleanly
  always_ff @(posedge CLK_OUT1) begin
    if (!rst_n) begin
      cpu_speed <= SPEED_3M5;
      out_ack   <= 1'b0;
    end else begin
      if (div_wrap && out_req && !out_ack) begin
        cpu_speed <= out_speed;
        out_ack   <= 1'b1;
      end else if (out_ack && !out_req) begin
        // Phase four of the handshake
        out_ack <= 1'b0;
      end
    end
  end

  // Divider bits that matter for the current rate
  always_comb begin
    case (cpu_speed)
      SPEED_14M: tc_mask = MASK_14M;
      SPEED_7M:  tc_mask = MASK_7M;
      SPEED_3M5: tc_mask = MASK_3M5;
      default:   tc_mask = MASK_3M5;
    endcase
  end

  assign term_cnt = ((div & tc_mask) == tc_mask);

  // Registered enable
  // Contention swallows the pulse, like the held-high CPU clock
  always_ff @(posedge CLK_OUT1) begin
    if (!rst_n) begin
      cpu_clken <= 1'b0;
    end else begin
      cpu_clken <= term_cnt && !cpu_contention;
    end
  end

  a_contention_gate : assert property (@(posedge CLK_OUT1) disable iff (!rst_n)
    cpu_contention |=> !cpu_clken)
    else $error("cpu_clken_gen: enable during contention");

  a_speed_at_wrap : assert property (@(posedge CLK_OUT1) disable iff (!rst_n)
    !$stable(cpu_speed) |-> $past(div_wrap))
    else $error("cpu_clken_gen: speed changed away from divider wrap");

endmodule

// ==== verilog/pll_reconf_seq.sv ====
`timescale 1ns/10ps

module pll_reconf_seq
  import clk_pkg::*;
(
  input  logic                 CLK_OUT1,
  input  logic                 rst_n,
  input  logic [PLL_OPT_W-1:0] pll_option,
  output logic                 reconf_step,
  output logic [PLL_OPT_W-1:0] reconf_state
);

  // One-hot delay chain, top bit is the step
  logic [RECONF_DELAY:0] chain;
  // Boot step pending after reset
  logic                  boot_q;
  logic                  restart;

  // New option, or the forced step after boot
  assign restart = (pll_option != reconf_state) || boot_q;

  always_ff @(posedge CLK_OUT1) begin
    if (!rst_n) begin
      reconf_state <= '0;
      chain        <= '0;
      boot_q       <= 1'b1;
    end else begin
      boot_q <= 1'b0;
      if (restart) begin
        // Store option and start counting again
        reconf_state <= pll_option;
        chain        <= {{RECONF_DELAY{1'b0}}, 1'b1};
      end else begin
        chain <= {chain[RECONF_DELAY-1:0], 1'b0};
      end
    end
  end

  // Registered bit, one cycle wide
  assign reconf_step = chain[RECONF_DELAY];

  a_step_single : assert property (@(posedge CLK_OUT1) disable iff (!rst_n)
    reconf_step |=> !reconf_step)
    else $error("pll_reconf_seq: step held for two cycles");

endmodule

// ==== verilog/clock_generator.sv ====
`timescale 1ns/10ps

module clock_generator
  import clk_pkg::*;
(
  input  logic                 CLK_OUT1,
  input  logic                 rst_n,
  input  logic [1:0]           turbo_enable,
  input  logic                 cpu_contention,
  input  logic [PLL_OPT_W-1:0] pll_option,
  output logic                 cpu_clken,
  output speed_t               cpu_speed,
  output logic                 reconf_step,
  output logic [PLL_OPT_W-1:0] reconf_state
);

  // Producer to FIFO link
  logic   in_req;
  speed_t in_speed;
  logic   in_ack;

  // FIFO to enable generator link
  logic   out_req;
  speed_t out_speed;
  logic   out_ack;

  // Turbo decode and request issue
  speed_request speed_request_i (
    .CLK_OUT1     (CLK_OUT1),
    .rst_n        (rst_n),
    .turbo_enable (turbo_enable),
    .in_req       (in_req),
    .in_speed     (in_speed),
    .in_ack       (in_ack)
  );

  // Request buffer
  speed_fifo speed_fifo_i (
    .CLK_OUT1  (CLK_OUT1),
    .rst_n     (rst_n),
    .in_req    (in_req),
    .in_speed  (in_speed),
    .in_ack    (in_ack),
    .out_req   (out_req),
    .out_speed (out_speed),
    .out_ack   (out_ack)
  );

  // Divider and CPU enable
  cpu_clken_gen cpu_clken_gen_i (
    .CLK_OUT1       (CLK_OUT1),
    .rst_n          (rst_n),
    .cpu_contention (cpu_contention),
    .out_req        (out_req),
    .out_speed      (out_speed),
    .out_ack        (out_ack),
    .cpu_clken      (cpu_clken),
    .cpu_speed      (cpu_speed)
  );

  // PLL reconfiguration sequencing
  pll_reconf_seq pll_reconf_seq_i (
    .CLK_OUT1     (CLK_OUT1),
    .rst_n        (rst_n),
    .pll_option   (pll_option),
    .reconf_step  (reconf_step),
    .reconf_state (reconf_state)
  );

endmodule

// ==== testbench/tb_clock_generator.sv ====
`timescale 1ns/10ps

module tb_clock_generator
  import clk_pkg::*;
();

  // Measurement windows and wait limits
  localparam int WINDOW       = 64;
  localparam int STEP_EDGES   = 7;
  localparam int STEP_LIMIT   = 32;
  localparam int SETTLE_RUN   = 100;
  localparam int SETTLE_LIMIT = 2000;

  logic        CLK_OUT1;
  logic        rst_n;
  logic [1:0]  turbo_enable;
  logic        cpu_contention;
  logic [2:0]  pll_option;
  logic        cpu_clken;
  speed_t      cpu_speed;
  logic        reconf_step;
  logic [2:0]  reconf_state;
  logic [31:0] lfsr;

  clock_generator dut_i (
    .CLK_OUT1       (CLK_OUT1),
    .rst_n          (rst_n),
    .turbo_enable   (turbo_enable),
    .cpu_contention (cpu_contention),
    .pll_option     (pll_option),
    .cpu_clken      (cpu_clken),
    .cpu_speed      (cpu_speed),
    .reconf_step    (reconf_step),
    .reconf_state   (reconf_state)
  );

  // 28 MHz master clock stand-in, 10 ns period
  always #5 CLK_OUT1 = ~CLK_OUT1;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped on first failure");
  endtask

  task automatic check_equal(input string what, input int actual, input int expected);
    if (actual != expected) begin
      abort_run($sformatf("error: time %0t: %s is %0d, expected %0d",
                          $time, what, actual, expected));
    end
  endtask

  // Rising edge, then 1 ns for drive and sample
  task automatic step_cycle();
    @(posedge CLK_OUT1);
    #1;
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // One LFSR step per bit
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // Bit 1 has priority over bit 0
  function automatic speed_t decode_turbo(input logic [1:0] t);
    if (t[1]) begin
      return SPEED_14M;
    end else if (t[0]) begin
      return SPEED_7M;
    end
    return SPEED_3M5;
  endfunction

  // Enables per window from the divide ratio
  function automatic int pulses_for(input speed_t s);
    case (s)
      SPEED_14M: return WINDOW / 2;
      SPEED_7M:  return WINDOW / 4;
      default:   return WINDOW / 8;
    endcase
  endfunction

  task automatic count_pulses(output int n);
    n = 0;
    repeat (WINDOW) begin
      step_cycle();
      if (cpu_clken) begin
        n++;
      end
    end
  endtask

  task automatic check_rate(input speed_t s);
    int n;
    count_pulses(n);
    check_equal("cpu_clken pulses per window", n, pulses_for(s));
  endtask

  // Speed must hold for a long run, so queued requests have drained
  task automatic settle_speed(input speed_t s);
    int     run;
    int     cycles;
    speed_t prev;
    run    = 0;
    cycles = 0;
    prev   = cpu_speed;
    while (run < SETTLE_RUN) begin
      if (cycles >= SETTLE_LIMIT) begin
        abort_run("timeout: cpu_speed never held steady after a turbo change");
      end
      step_cycle();
      cycles++;
      if (cpu_speed == prev) begin
        run++;
      end else begin
        run = 0;
      end
      prev = cpu_speed;
    end
    check_equal("cpu_speed", int'(cpu_speed), int'(s));
  endtask

  // Called just after the edge that stored the option
  task automatic expect_single_step();
    int n;
    n = 0;
    while (!reconf_step) begin
      if (n >= STEP_LIMIT) begin
        abort_run("timeout: no reconfiguration step after the option update");
      end
      step_cycle();
      n++;
    end
    check_equal("edges to reconf_step", n, STEP_EDGES);
    // No second pulse
    repeat (16) begin
      step_cycle();
      check_equal("reconf_step after pulse", int'(reconf_step), 0);
    end
  endtask

  task automatic reset_and_boot();
    // First edge with reset released
    step_cycle();
    check_equal("cpu_speed after reset", int'(cpu_speed), int'(SPEED_3M5));
    check_equal("reconf_state after reset", int'(reconf_state), 0);
    check_equal("reconf_step after reset", int'(reconf_step), 0);
    expect_single_step();
    check_rate(SPEED_3M5);
  endtask

  task automatic speed_selection();
    for (int t = 1; t <= 4; t++) begin
      // 1, 2, 3, then back to 0
      turbo_enable = t[1:0];
      settle_speed(decode_turbo(t[1:0]));
      check_rate(decode_turbo(t[1:0]));
    end
  endtask

  task automatic contention_gating();
    int n;
    turbo_enable = 2'b10;
    settle_speed(SPEED_14M);
    cpu_contention = 1'b1;
    count_pulses(n);
    check_equal("cpu_clken pulses under contention", n, 0);
    cpu_contention = 1'b0;
    check_rate(SPEED_14M);
  endtask

  // Turbo changes on every cycle, a long burst fills the FIFO
  task automatic request_burst(input int len, input int mult, input int offs);
    int v;
    v = 0;
    for (int i = 0; i < len; i++) begin
      v            = (offs + i * mult) % 4;
      turbo_enable = v[1:0];
      step_cycle();
    end
    settle_speed(decode_turbo(v[1:0]));
    check_rate(decode_turbo(v[1:0]));
  endtask

  task automatic pll_single_change(input logic [2:0] opt);
    pll_option = opt;
    step_cycle();
    check_equal("reconf_state", int'(reconf_state), int'(opt));
    expect_single_step();
  endtask

  // Second change three cycles later restarts the chain
  task automatic pll_double_change(input logic [2:0] a, input logic [2:0] b);
    pll_option = a;
    step_cycle();
    check_equal("reconf_state first change", int'(reconf_state), int'(a));
    repeat (2) begin
      step_cycle();
      check_equal("reconf_step between changes", int'(reconf_step), 0);
    end
    pll_option = b;
    step_cycle();
    check_equal("reconf_state second change", int'(reconf_state), int'(b));
    expect_single_step();
  endtask

  task automatic random_sequence(input int iters);
    logic [31:0] tb;
    logic [31:0] ob;
    logic [2:0]  prev_opt;
    for (int i = 0; i < iters; i++) begin
      take_bits(2, tb);
      take_bits(3, ob);
      prev_opt     = pll_option;
      turbo_enable = tb[1:0];
      pll_option   = ob[2:0];
      step_cycle();
      check_equal("reconf_state random", int'(reconf_state), int'(ob[2:0]));
      if (ob[2:0] != prev_opt) begin
        expect_single_step();
      end
      settle_speed(decode_turbo(tb[1:0]));
      check_rate(decode_turbo(tb[1:0]));
    end
  endtask

  initial begin
    CLK_OUT1       = 1'b0;
    rst_n          = 1'b0;
    turbo_enable   = 2'b00;
    cpu_contention = 1'b0;
    pll_option     = 3'd0;
    lfsr           = 32'h2153c06b;
    repeat (4) @(posedge CLK_OUT1);
    #1;
    rst_n = 1'b1;

    reset_and_boot();
    speed_selection();
    contention_gating();
    request_burst(64, 3, 1);
    request_burst(12, 1, 2);
    pll_single_change(3'd5);
    pll_double_change(3'd2, 3'd6);
    random_sequence(8);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== src.f ====
verilog/clk_pkg.sv
verilog/speed_request.sv
verilog/speed_fifo.sv
verilog/cpu_clken_gen.sv
verilog/pll_reconf_seq.sv
verilog/clock_generator.sv
testbench/tb_clock_generator.sv

// ==== Makefile ====
TOP := tb_clock_generator
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f src.f

sim:
	rm -f $(LOG)
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f src.f
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
